//--- flist.f
logic/rv_pkg.sv
logic/rv_pc.sv
logic/rv_imem.sv
logic/rv_idec.sv
logic/rv_alu.sv
logic/rv_regfile.sv
logic/rv_exec.sv
logic/rv_core.sv
dv/rv_tb_clk.sv
dv/rv_core_assert.sv
dv/rv_core_tb.sv

//--- dv/rv_core_tb.sv
module rv_core_tb
  import rv_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_WAIT = 200;

  logic       clk;
  logic       rst_n;
  logic       imem_we;
  imem_addr_t imem_waddr;
  instr_t     imem_wdata;
  logic       retire;
  xlen_t      retire_pc;
  wb_t        wb;
  logic       ebreak;

  instr_t      prog [$];
  xlen_t       model_regs [32];
  int unsigned cycle = 0;
  int          errors = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;

  rv_tb_clk clk_gen (.clk(clk));

  rv_core rv_core_i (.*);

  // Cycle 1 is the first cycle with rst_n high
  always @(posedge clk) begin
    cycle <= rst_n ? cycle + 1 : 0;
  end

  task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      $display("error %s: got %08h, expected %08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
      $display("error %s: got %02h, expected %02h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error %s: got %0h, expected %0h", name, got, exp);
      errors++;
    end
  endtask

  function automatic instr_t enc_i(logic [6:0] opc, logic [2:0] f3, reg_addr_t rd,
                                   reg_addr_t rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic instr_t enc_r(logic [6:0] f7, logic [2:0] f3, reg_addr_t rd,
                                   reg_addr_t rs1, reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, OP};
  endfunction

  function automatic instr_t enc_u(logic [6:0] opc, reg_addr_t rd, logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  // LUI then ADDI, upper part rounded since ADDI sign-extends
  task automatic push_const(input reg_addr_t rd, input xlen_t v);
    xlen_t hi;
    hi = v + 32'h800;
    prog.push_back(enc_u(LUI, rd, hi[31:12]));
    prog.push_back(enc_i(OP_IMM, 3'b000, rd, rd, v[11:0]));
  endtask

  function automatic xlen_t alu_ref(logic [2:0] f3, logic alt, xlen_t a, xlen_t b);
    logic signed [31:0] sa;
    sa = a;
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return xlen_t'(sa < $signed(b));
      3'b011:  return xlen_t'(a < b);
      3'b100:  return a ^ b;
      3'b101:  return alt ? xlen_t'(sa >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // Reference model, updates model_regs as the core would
  function automatic wb_t predict(instr_t ins, xlen_t pc);
    wb_t        exp;
    logic [6:0] f7;
    logic [2:0] f3;
    logic       ok;
    f7       = ins[31:25];
    f3       = ins[14:12];
    exp.rd   = ins[11:7];
    exp.data = '0;
    ok       = 1'b1;
    case (ins[6:0])
      OP_IMM: begin
        if (f3 == 3'b001) ok = (f7 == 7'h00);
        if (f3 == 3'b101) ok = (f7 == 7'h00) || (f7 == 7'h20);
        exp.data = alu_ref(f3, f3 == 3'b101 && f7 == 7'h20, model_regs[ins[19:15]],
                           {{20{ins[31]}}, ins[31:20]});
      end
      OP: begin
        ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
        exp.data = alu_ref(f3, f7 == 7'h20, model_regs[ins[19:15]], model_regs[ins[24:20]]);
      end
      LUI:     exp.data = {ins[31:12], 12'h000};
      AUIPC:   exp.data = pc + {ins[31:12], 12'h000};
      default: ok = 1'b0;  // EBREAK and unsupported encodings
    endcase
    exp.en = ok && (exp.rd != '0);
    if (exp.en) model_regs[exp.rd] = exp.data;
    return exp;
  endfunction

  task automatic wait_retire(input int k, output bit seen);
    seen = 1'b0;
    for (int n = 0; n < MAX_WAIT && !seen; n++) begin
      @(negedge clk);
      seen = (retire === 1'b1);
    end
    if (!seen) begin
      $display("timeout: retire of word %0d did not come within %0d cycles", k, MAX_WAIT);
      errors++;
    end
  endtask

  task automatic wait_ebreak();
    bit seen;
    seen = 1'b0;
    for (int n = 0; n < MAX_WAIT && !seen; n++) begin
      @(negedge clk);
      seen = (ebreak === 1'b1);
    end
    if (!seen) begin
      $display("timeout: ebreak did not rise within %0d cycles", MAX_WAIT);
      errors++;
    end
  endtask

  // Program goes in while rst_n is low, then 3 more reset cycles
  task automatic load_in_reset();
    @(negedge clk);
    rst_n = 1'b0;
    foreach (prog[i]) begin
      imem_we    = 1'b1;
      imem_waddr = imem_addr_t'(i);
      imem_wdata = prog[i];
      @(negedge clk);
    end
    imem_we = 1'b0;
    repeat (3) @(negedge clk);
  endtask

  task automatic release_reset();
    rst_n = 1'b1;
    foreach (model_regs[i]) model_regs[i] = '0;
  endtask

  task automatic check_retires(input int n);
    bit  seen;
    wb_t exp;
    for (int k = 0; k < n; k++) begin
      wait_retire(k, seen);
      if (!seen) return;
      check_word("retire_cycle", xlen_t'(cycle), xlen_t'(k + 2));
      check_word("retire_pc", retire_pc, xlen_t'(4 * k));
      exp = predict(prog[k], xlen_t'(4 * k));
      check_bit("wb.en", wb.en, exp.en);
      if (exp.en) begin
        check_reg("wb.rd", wb.rd, exp.rd);
        check_word("wb.data", wb.data, exp.data);
      end
    end
  endtask

  task automatic run_program();
    prog.push_back(I_EBREAK);
    load_in_reset();
    release_reset();
    check_retires(prog.size());
    wait_ebreak();
  endtask

  task automatic finish_test(input string name);
    if (errors == 0) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors);
    end
    errors = 0;
  endtask

  task automatic test_reset_state();
    prog.delete();
    prog.push_back(enc_i(OP_IMM, 3'b000, 5'd1, 5'd0, 12'h123));
    prog.push_back(I_EBREAK);
    load_in_reset();
    check_bit("retire", retire, 1'b0);
    check_bit("wb.en", wb.en, 1'b0);
    check_bit("ebreak", ebreak, 1'b0);
    release_reset();
    @(negedge clk);
    check_bit("retire", retire, 1'b0);
    check_bit("wb.en", wb.en, 1'b0);
    check_bit("ebreak", ebreak, 1'b0);
    check_retires(prog.size());
    finish_test("reset_state");
  endtask

  task automatic test_retire_order();
    prog.delete();
    for (int k = 0; k < 8; k++) begin
      prog.push_back(enc_i(OP_IMM, 3'b000, reg_addr_t'(k + 1), reg_addr_t'(k), 12'(3 * k + 1)));
    end
    run_program();
    finish_test("retire_order");
  endtask

  task automatic test_imm_ops();
    prog.delete();
    push_const(5'd1, $urandom());
    push_const(5'd2, $urandom() | 32'h8000_0000);  // Negative source
    prog.push_back(enc_i(OP_IMM, 3'b000, 5'd3, 5'd1, 12'($urandom())));
    prog.push_back(enc_i(OP_IMM, 3'b010, 5'd4, 5'd2, 12'($urandom()) | 12'h800));
    prog.push_back(enc_i(OP_IMM, 3'b011, 5'd5, 5'd1, 12'($urandom())));
    prog.push_back(enc_i(OP_IMM, 3'b100, 5'd6, 5'd2, 12'($urandom())));
    prog.push_back(enc_i(OP_IMM, 3'b110, 5'd7, 5'd1, 12'($urandom())));
    prog.push_back(enc_i(OP_IMM, 3'b111, 5'd8, 5'd2, 12'($urandom())));
    prog.push_back(enc_i(OP_IMM, 3'b001, 5'd9, 5'd1, {7'h00, 5'($urandom())}));
    prog.push_back(enc_i(OP_IMM, 3'b101, 5'd10, 5'd2, {7'h00, 5'($urandom())}));
    prog.push_back(enc_i(OP_IMM, 3'b101, 5'd11, 5'd2, {7'h20, 5'($urandom())}));
    run_program();
    finish_test("imm_ops");
  endtask

  task automatic test_reg_ops();
    prog.delete();
    push_const(5'd1, $urandom());
    push_const(5'd2, $urandom() | 32'h8000_0000);
    push_const(5'd3, $urandom());
    // Each result feeds the next instruction
    prog.push_back(enc_r(7'h00, 3'b000, 5'd4, 5'd1, 5'd2));
    prog.push_back(enc_r(7'h20, 3'b000, 5'd5, 5'd4, 5'd3));
    prog.push_back(enc_r(7'h00, 3'b001, 5'd6, 5'd5, 5'd1));
    prog.push_back(enc_r(7'h00, 3'b010, 5'd7, 5'd2, 5'd6));
    prog.push_back(enc_r(7'h00, 3'b011, 5'd8, 5'd7, 5'd2));
    prog.push_back(enc_r(7'h00, 3'b100, 5'd9, 5'd8, 5'd1));
    prog.push_back(enc_r(7'h00, 3'b101, 5'd10, 5'd2, 5'd9));
    prog.push_back(enc_r(7'h20, 3'b101, 5'd11, 5'd2, 5'd10));
    prog.push_back(enc_r(7'h00, 3'b110, 5'd12, 5'd11, 5'd5));
    prog.push_back(enc_r(7'h00, 3'b111, 5'd13, 5'd12, 5'd4));
    prog.push_back(enc_r(7'h00, 3'b011, 5'd14, 5'd1, 5'd2));
    prog.push_back(enc_r(7'h00, 3'b010, 5'd15, 5'd1, 5'd2));
    run_program();
    finish_test("reg_ops");
  endtask

  task automatic test_special();
    prog.delete();
    prog.push_back(enc_u(LUI, 5'd1, 20'($urandom())));
    prog.push_back(enc_u(AUIPC, 5'd2, 20'($urandom())));
    prog.push_back(enc_i(OP_IMM, 3'b000, 5'd0, 5'd1, 12'h7ff));  // Dropped write to x0
    prog.push_back(enc_r(7'h00, 3'b000, 5'd3, 5'd0, 5'd2));
    prog.push_back(enc_i(7'b0000011, 3'b010, 5'd4, 5'd1, 12'h000));  // LW is not supported
    prog.push_back(enc_r(7'h00, 3'b110, 5'd5, 5'd4, 5'd0));
    run_program();
    finish_test("special");
  endtask

  task automatic test_halt();
    prog.delete();
    prog.push_back(enc_i(OP_IMM, 3'b000, 5'd1, 5'd0, 12'h011));
    prog.push_back(I_EBREAK);
    prog.push_back(enc_i(OP_IMM, 3'b000, 5'd2, 5'd0, 12'h022));
    prog.push_back(enc_i(OP_IMM, 3'b000, 5'd3, 5'd0, 12'h033));
    prog.push_back(I_EBREAK);
    // Second round checks that reset clears the halt
    for (int run = 0; run < 2; run++) begin
      load_in_reset();
      check_bit("ebreak", ebreak, 1'b0);
      release_reset();
      check_retires(2);
      @(negedge clk);
      check_bit("ebreak", ebreak, 1'b1);
      repeat (20) begin
        check_bit("retire", retire, 1'b0);
        check_bit("ebreak", ebreak, 1'b1);
        @(negedge clk);
      end
    end
    finish_test("halt");
  endtask

  initial begin
    rst_n      = 1'b0;
    imem_we    = 1'b0;
    imem_waddr = '0;
    imem_wdata = '0;
    void'($urandom(32'h33249244));
    test_reset_state();
    test_retire_order();
    test_imm_ops();
    test_reg_ops();
    test_special();
    test_halt();
    $display("tests passed %0d, failed %0d, assertion failures %0d",
             tests_passed, tests_failed, rv_core_i.core_assert_i.fire_count);
    if (tests_failed == 0 && rv_core_i.core_assert_i.fire_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- dv/rv_core_assert.sv
module rv_core_assert
  import rv_pkg::*;
(
  input logic clk,
  input logic rst_n,
  input logic retire,
  input wb_t  wb,
  input logic ebreak
);

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fire_count = 0;  // Read by the testbench at the end of the run

  wb_needs_retire: assert property (@(posedge clk) disable iff (!rst_n) wb.en |-> retire)
    else begin
      fire_count++;
      $error("wb.en high without retire");
    end

  wb_rd_nonzero: assert property (@(posedge clk) disable iff (!rst_n) wb.en |-> wb.rd != '0)
    else begin
      fire_count++;
      $error("wb.en high with wb.rd zero");
    end

  no_retire_halted: assert property (@(posedge clk) disable iff (!rst_n) ebreak |-> !retire)
    else begin
      fire_count++;
      $error("retire while ebreak is high");
    end

  // Halt is sticky until the next reset
  ebreak_sticky: assert property (@(posedge clk) disable iff (!rst_n) ebreak |=> ebreak)
    else begin
      fire_count++;
      $error("ebreak dropped while out of reset");
    end

endmodule

bind rv_core rv_core_assert core_assert_i (.*);

//--- dv/rv_tb_clk.sv
module rv_tb_clk (
  output logic clk
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

endmodule

//--- logic/rv_core.sv
module rv_core
  import rv_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  input  logic       imem_we,
  input  imem_addr_t imem_waddr,
  input  instr_t     imem_wdata,

  output logic       retire,
  output xlen_t      retire_pc,
  output wb_t        wb,
  output logic       ebreak
);

  logic   halted;
  logic   fetch;
  xlen_t  pc;
  fetch_t fetch_q;  // Registered word and its pc
  dec_t   dec;

  rv_pc pc_seq (
    .clk   (clk),
    .rst_n (rst_n),
    .halted(halted),
    .fetch (fetch),
    .pc    (pc)
  );

  rv_imem imem (
    .clk       (clk),
    .imem_we   (imem_we),
    .imem_waddr(imem_waddr),
    .imem_wdata(imem_wdata),
    .fetch     (fetch),
    .pc        (pc),
    .fetch_out (fetch_q)
  );

  rv_idec idec (
    .fetch_in(fetch_q),
    .dec     (dec)
  );

  rv_exec exec (
    .clk      (clk),
    .rst_n    (rst_n),
    .dec      (dec),
    .pc       (fetch_q.pc),
    .retire   (retire),
    .retire_pc(retire_pc),
    .wb       (wb),
    .halted   (halted)
  );

  assign ebreak = halted;

endmodule

//--- logic/rv_exec.sv
module rv_exec
  import rv_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,

  input  dec_t  dec,
  input  xlen_t pc,

  output logic  retire,
  output xlen_t retire_pc,
  output wb_t   wb,
  output logic  halted
);

  xlen_t rdata1;
  xlen_t rdata2;
  xlen_t alu_a;
  xlen_t alu_b;
  xlen_t alu_y;

  rv_regfile regfile (
    .clk   (clk),
    .rst_n (rst_n),
    .rs1   (dec.rs1),
    .rs2   (dec.rs2),
    .rdata1(rdata1),
    .rdata2(rdata2),
    .wb    (wb)
  );

  // LUI adds to zero, AUIPC adds to its own pc
  assign alu_a = dec.a_is_zero ? '0 :
                 dec.a_is_pc   ? pc : rdata1;
  assign alu_b = dec.b_is_imm ? dec.imm : rdata2;

  rv_alu alu (
    .op(dec.alu_op),
    .a (alu_a),
    .b (alu_b),
    .y (alu_y)
  );

  assign retire    = dec.valid && !halted;  // Drops the fetch behind EBREAK
  assign retire_pc = pc;
  assign wb        = '{en: retire && dec.reg_write, rd: dec.rd, data: alu_y};

  // Sticky until reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      halted <= 1'b0;
    end else if (retire && dec.is_ebreak) begin
      halted <= 1'b1;
    end
  end

endmodule

//--- logic/rv_regfile.sv
module rv_regfile
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  output xlen_t     rdata1,
  output xlen_t     rdata2,
  input  wb_t       wb
);

  xlen_t regs [1:31];  // x0 has no storage

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.en && wb.rd != '0) begin
      regs[wb.rd] <= wb.data;
    end
  end

  assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- logic/rv_alu.sv
module rv_alu
  import rv_pkg::*;
(
  input  alu_op_e op,
  input  xlen_t   a,
  input  xlen_t   b,
  output xlen_t   y
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      ALU_ADD: begin
        y = a + b;
      end
      ALU_SUB: begin
        y = a - b;
      end
      ALU_SLL: begin
        y = a << shamt;
      end
      ALU_SLT: begin
        y = {31'b0, $signed(a) < $signed(b)};
      end
      ALU_SLTU: begin
        y = {31'b0, a < b};
      end
      ALU_XOR: begin
        y = a ^ b;
      end
      ALU_SRL: begin
        y = a >> shamt;
      end
      ALU_SRA: begin
        y = xlen_t'($signed(a) >>> shamt);  // Sign fills from the top
      end
      ALU_OR: begin
        y = a | b;
      end
      ALU_AND: begin
        y = a & b;
      end
      default: begin
        y = '0;
      end
    endcase
  end

endmodule

//--- logic/rv_idec.sv
module rv_idec
  import rv_pkg::*;
(
  input  fetch_t fetch_in,
  output dec_t   dec
);

  instr_t     instr;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i;
  xlen_t      imm_u;
  logic       supported;

  assign instr  = fetch_in.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};  // Sign extended
  assign imm_u = {instr[31:12], 12'b0};

  // Shared funct3 map for OP and OP-IMM; alt selects SUB or SRA
  function automatic alu_op_e f3_to_op(logic [2:0] f3, logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    dec       = '0;
    supported = 1'b0;

    dec.valid  = fetch_in.valid;
    dec.rd     = instr[11:7];
    dec.rs1    = instr[19:15];
    dec.rs2    = instr[24:20];
    dec.alu_op = ALU_ADD;

    case (opcode)
      OP_IMM: begin
        dec.b_is_imm = 1'b1;
        dec.imm      = imm_i;
        // ADDI has no SUB form, only SRAI uses the alt bit
        dec.alu_op   = f3_to_op(funct3, (funct3 == 3'b101) && funct7[5]);
        case (funct3)
          3'b001:  supported = (funct7 == 7'b0000000);
          3'b101:  supported = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
          default: supported = 1'b1;
        endcase
      end
      OP: begin
        dec.alu_op = f3_to_op(funct3, funct7[5]);
        supported  = (funct7 == 7'b0000000) ||
                     ((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      LUI: begin
        dec.a_is_zero = 1'b1;
        dec.b_is_imm  = 1'b1;
        dec.imm       = imm_u;
        supported     = 1'b1;
      end
      AUIPC: begin
        dec.a_is_pc  = 1'b1;
        dec.b_is_imm = 1'b1;
        dec.imm      = imm_u;
        supported    = 1'b1;
      end
      default: begin
        supported = 1'b0;  // EBREAK writes nothing
      end
    endcase

    dec.reg_write = supported && (dec.rd != '0);
    dec.is_ebreak = (instr == I_EBREAK);
  end

endmodule

//--- logic/rv_imem.sv
module rv_imem
  import rv_pkg::*;
(
  input  logic       clk,

  input  logic       imem_we,
  input  imem_addr_t imem_waddr,
  input  instr_t     imem_wdata,

  input  logic       fetch,
  input  xlen_t      pc,
  output fetch_t     fetch_out
);

  instr_t     mem [2**IMEM_AW];
  imem_addr_t raddr;

  assign raddr = pc[IMEM_AW+1:2];  // Word address

  // Load port, open in and out of reset
  always_ff @(posedge clk) begin
    if (imem_we) begin
      mem[imem_waddr] <= imem_wdata;
    end
  end

  // Fetch strobe is held low in reset, so valid clears there too
  always_ff @(posedge clk) begin
    fetch_out.valid <= fetch;
    if (fetch) begin
      fetch_out.instr <= mem[raddr];
      fetch_out.pc    <= pc;  // Address travels with the word
    end
  end

endmodule

//--- logic/rv_pc.sv
module rv_pc
  import rv_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  halted,
  output logic  fetch,
  output xlen_t pc
);

  logic running;

  // Fetch starts the cycle after reset is released
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      running <= 1'b0;
    end else begin
      running <= 1'b1;
    end
  end

  assign fetch = running && !halted;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (fetch) begin
      pc <= pc + xlen_t'(4);  // One word per fetch
    end
  end

endmodule

//--- logic/rv_pkg.sv
package rv_pkg;

  localparam int XLEN    = 32;
  localparam int IMEM_AW = 8;  // 256 instruction words

  // Major opcodes, instr[6:0]
  localparam logic [6:0] OP_IMM = 7'b0010011;
  localparam logic [6:0] OP     = 7'b0110011;
  localparam logic [6:0] LUI    = 7'b0110111;
  localparam logic [6:0] AUIPC  = 7'b0010111;
  localparam logic [6:0] SYSTEM = 7'b1110011;

  localparam logic [31:0] I_EBREAK = 32'h0010_0073;

  typedef logic [XLEN-1:0]    xlen_t;
  typedef logic [31:0]        instr_t;
  typedef logic [4:0]         reg_addr_t;
  typedef logic [IMEM_AW-1:0] imem_addr_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  typedef struct packed {
    logic   valid;
    xlen_t  pc;
    instr_t instr;
  } fetch_t;

  typedef struct packed {
    logic      valid;
    alu_op_e   alu_op;
    logic      a_is_pc;    // AUIPC
    logic      b_is_imm;
    logic      a_is_zero;  // LUI
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    xlen_t     imm;
    logic      reg_write;
    logic      is_ebreak;
  } dec_t;

  typedef struct packed {
    logic      en;
    reg_addr_t rd;
    xlen_t     data;
  } wb_t;

endpackage
